// File: verilog.f
rtl/axiw_pkg.sv
rtl/axil_wr_if.sv
rtl/sync_fifo_zl.sv
rtl/axi_axil_reflect_wr.sv
rtl/axil_reg_bank.sv
rtl/axi_wr_bridge_top.sv
sim/tb_clkgen.sv
sim/axi_wr_bridge_assert.sv
sim/axi_wr_bridge_tb.sv

// File: Bender.yml
package:
  name: axi_wr_bridge

sources:
  - rtl/axiw_pkg.sv
  - rtl/axil_wr_if.sv
  - rtl/sync_fifo_zl.sv
  - rtl/axi_axil_reflect_wr.sv
  - rtl/axil_reg_bank.sv
  - rtl/axi_wr_bridge_top.sv
  - target: simulation
    files:
      - sim/tb_clkgen.sv
      - sim/axi_wr_bridge_assert.sv
      - sim/axi_wr_bridge_tb.sv

// File: sim/axi_wr_bridge_tb.sv
`timescale 1ns/1ps

module axi_wr_bridge_tb;
  import axiw_pkg::*;

  localparam int NUM_ROWS   = 14;
  localparam int W_LEAD     = 3;
  localparam int TIMEOUT_NS = (NUM_ROWS * 40 + 16) * 40;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
    logic [USER_W-1:0] user;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              w_first;
    logic [1:0]        resp;
  } row_t;

  // One expected B response, with the register value it leaves behind
  typedef struct packed {
    logic [ID_W-1:0]      id;
    logic [USER_W-1:0]    user;
    logic [1:0]           resp;
    logic [REG_IDX_W-1:0] idx;
    logic [DATA_W-1:0]    val;
  } exp_t;

  logic                 clk, i_rst_n;
  logic                 i_awvalid, o_awready, i_wvalid, o_wready, o_bvalid, i_bready;
  logic [ADDR_W-1:0]    i_awaddr;
  logic [ID_W-1:0]      i_awid, o_bid;
  logic [USER_W-1:0]    i_awuser, o_buser;
  logic [DATA_W-1:0]    i_wdata, o_rd_data;
  logic [STRB_W-1:0]    i_wstrb;
  logic [1:0]           o_bresp;
  logic [REG_IDX_W-1:0] i_rd_idx;

  int                errors = 0;
  int                checks = 0;
  int                out_cnt = 0;
  int                b_seen = 0;
  logic [31:0]       lfsr = 32'h2d7a_930b;
  logic [DATA_W-1:0] model [NUM_REGS];
  exp_t              exp_q [$];

  // addr, id, user, data, strb, W leads AW, expected response
  row_t tbl [NUM_ROWS] = '{
    '{8'h00, 4'h1, 1'b1, 16'ha5c3, 2'b11, 1'b0, RESP_OKAY},
    '{8'h1e, 4'h2, 1'b0, 16'h1234, 2'b11, 1'b1, RESP_OKAY},
    '{8'h04, 4'h3, 1'b1, 16'hbeef, 2'b11, 1'b0, RESP_OKAY},
    '{8'h04, 4'h4, 1'b0, 16'h7755, 2'b01, 1'b0, RESP_OKAY},
    '{8'h05, 4'h5, 1'b1, 16'h9911, 2'b10, 1'b1, RESP_OKAY},
    '{8'h20, 4'h6, 1'b0, 16'hdead, 2'b11, 1'b0, RESP_SLVERR},
    '{8'hff, 4'h7, 1'b1, 16'hcafe, 2'b11, 1'b1, RESP_SLVERR},
    '{8'h0a, 4'h8, 1'b0, 16'h0f0f, 2'b11, 1'b0, RESP_OKAY},
    '{8'h0b, 4'h9, 1'b1, 16'hf0aa, 2'b10, 1'b0, RESP_OKAY},
    '{8'h10, 4'ha, 1'b0, 16'h5a5a, 2'b11, 1'b1, RESP_OKAY},
    '{8'h10, 4'hb, 1'b1, 16'h00c3, 2'b01, 1'b0, RESP_OKAY},
    '{8'h21, 4'hc, 1'b0, 16'h1111, 2'b11, 1'b0, RESP_SLVERR},
    '{8'h02, 4'hd, 1'b1, 16'h1357, 2'b00, 1'b1, RESP_OKAY},
    '{8'h1e, 4'he, 1'b0, 16'hffff, 2'b01, 1'b0, RESP_OKAY}
  };

  tb_clkgen #(.PERIOD_NS(40)) u_clkgen (.o_clk(clk));

  axi_wr_bridge_top dut0 (.*);

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                    input logic [DATA_W-1:0] data,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    errors++;
    $display("error at %0t: %s = %h, expected %h", $time, name, got, want);
  endtask

  task automatic compare_all_regs();
    for (int i = 0; i < NUM_REGS; i++) begin
      @(posedge clk);
      i_rd_idx <= REG_IDX_W'(i);
      @(negedge clk);
      checks++;
      if (o_rd_data !== model[i]) report_mismatch("o_rd_data", o_rd_data, model[i]);
    end
  endtask

  // Present one row, leading channel first, and hold each valid until accepted
  task automatic send_row(input int r);
    row_t row;
    int   cyc;
    int   aw_at;
    int   w_at;
    bit   aw_on;
    bit   w_on;
    bit   aw_done;
    bit   w_done;
    row = tbl[r];
    aw_at = row.w_first ? W_LEAD : 0;
    w_at  = row.w_first ? 0 : r % 3;
    if (row.addr < NUM_REGS * 2) begin
      model[row.addr[REG_IDX_W:1]] = merge_bytes(model[row.addr[REG_IDX_W:1]], row.data,
                                                 row.strb);
    end
    exp_q.push_back('{row.id, row.user, row.resp, row.addr[REG_IDX_W:1],
                      model[row.addr[REG_IDX_W:1]]});
    cyc = 0;
    aw_on = 0;
    w_on = 0;
    aw_done = 0;
    w_done = 0;
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      if (aw_done) i_awvalid <= 1'b0;
      if (w_done) i_wvalid <= 1'b0;
      if (!aw_on && cyc == aw_at) begin
        i_awvalid <= 1'b1;
        i_awaddr  <= row.addr;
        i_awid    <= row.id;
        i_awuser  <= row.user;
        aw_on = 1;
      end
      if (!w_on && cyc == w_at) begin
        i_wvalid <= 1'b1;
        i_wdata  <= row.data;
        i_wstrb  <= row.strb;
        w_on = 1;
      end
      cyc++;
      @(negedge clk);
      if (aw_on && o_awready) aw_done = 1;
      if (w_on && o_wready) w_done = 1;
    end
    @(posedge clk);
    i_awvalid <= 1'b0;
    i_wvalid  <= 1'b0;
  endtask

  // Random B stalls and response checking
  initial begin
    exp_t e;
    forever begin
      @(posedge clk);
      i_bready <= lfsr[0];
      lfsr = lfsr_next(lfsr);
      if (exp_q.size() != 0) i_rd_idx <= exp_q[0].idx;
      @(negedge clk);
      if (i_rst_n) begin
        if (out_cnt >= ID_DEPTH && o_awready !== 1'b0) report_mismatch("o_awready", o_awready, 0);
        if (out_cnt >= ID_DEPTH && o_wready !== 1'b0) report_mismatch("o_wready", o_wready, 0);
        if (o_bvalid && i_bready) begin
          if (exp_q.size() == 0) begin
            errors++;
            $display("B response at %0t with no write outstanding", $time);
          end else begin
            e = exp_q.pop_front();
            checks++;
            if (o_bid !== e.id) report_mismatch("o_bid", o_bid, e.id);
            if (o_buser !== e.user) report_mismatch("o_buser", o_buser, e.user);
            if (o_bresp !== e.resp) report_mismatch("o_bresp", o_bresp, e.resp);
            if (o_rd_data !== e.val) report_mismatch("o_rd_data", o_rd_data, e.val);
          end
          out_cnt--;
          b_seen++;
        end
        if (i_awvalid && o_awready) out_cnt++;
      end
    end
  end

  initial begin
    i_rst_n   = 1'b0;
    i_awvalid = 1'b0;
    i_awaddr  = '0;
    i_awid    = '0;
    i_awuser  = '0;
    i_wvalid  = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_bready  = 1'b0;
    i_rd_idx  = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model[i] = '0;
    end
    repeat (16) @(posedge clk);
    i_rst_n <= 1'b1;
    @(negedge clk);
    checks++;
    if (o_bvalid !== 1'b0) report_mismatch("o_bvalid", o_bvalid, 0);
    if (o_awready !== 1'b1) report_mismatch("o_awready", o_awready, 1);
    if (o_wready !== 1'b1) report_mismatch("o_wready", o_wready, 1);
    compare_all_regs();
    for (int r = 0; r < NUM_ROWS; r++) begin
      send_row(r);
    end
    while (exp_q.size() != 0) @(posedge clk);
    compare_all_regs();
    if (b_seen != NUM_ROWS) begin
      errors++;
      $display("Saw %0d B responses for %0d writes", b_seen, NUM_ROWS);
    end
    errors += dut0.u_bridge_assert.assert_fails;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, the DUT stopped responding", TIMEOUT_NS);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: sim/axi_wr_bridge_assert.sv
`timescale 1ns/1ps

module axi_wr_bridge_assert (
  input logic                        clk,
  input logic                        i_rst_n,
  input logic                        i_awvalid,
  input logic                        i_awready,
  input logic                        i_bvalid,
  input logic                        i_bready,
  input logic [axiw_pkg::ID_W-1:0]   i_bid,
  input logic [axiw_pkg::USER_W-1:0] i_buser,
  input logic [1:0]                  i_bresp
);
  import axiw_pkg::*;

  int         assert_fails = 0;
  logic [2:0] in_flight;
  logic       aw_hs;
  logic       b_hs;

  assign aw_hs = i_awvalid && i_awready;
  assign b_hs  = i_bvalid && i_bready;

  // Writes accepted on AW but not yet answered on B
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + 3'(aw_hs) - 3'(b_hs);
    end
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_bvalid && !i_bready |=> i_bvalid)
    else begin
      assert_fails++;
      $error("B valid dropped before its handshake");
    end

  a_b_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_bvalid && !i_bready |=> $stable({i_bid, i_buser, i_bresp}))
    else begin
      assert_fails++;
      $error("B payload changed while the response was stalled");
    end

  a_in_flight_cap: assert property (@(posedge clk) disable iff (!i_rst_n)
    in_flight <= 3'(ID_DEPTH))
    else begin
      assert_fails++;
      $error("More writes in flight than the ID FIFO can hold");
    end

  a_no_spurious_b: assert property (@(posedge clk) disable iff (!i_rst_n)
    $rose(i_bvalid) |-> in_flight != '0)
    else begin
      assert_fails++;
      $error("B valid rose with no write in flight");
    end

endmodule

bind axi_wr_bridge_top axi_wr_bridge_assert u_bridge_assert (
  .clk      (clk),
  .i_rst_n  (i_rst_n),
  .i_awvalid(i_awvalid),
  .i_awready(o_awready),
  .i_bvalid (o_bvalid),
  .i_bready (i_bready),
  .i_bid    (o_bid),
  .i_buser  (o_buser),
  .i_bresp  (o_bresp)
);

// File: sim/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS = 40
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  // Free-running, 50% duty
  always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

// File: rtl/axi_wr_bridge_top.sv
`timescale 1ns/1ps

module axi_wr_bridge_top (
  input  logic                           clk,
  input  logic                           i_rst_n,

  // AXI write address
  input  logic                           i_awvalid,
  input  logic [axiw_pkg::ADDR_W-1:0]    i_awaddr,
  input  logic [axiw_pkg::ID_W-1:0]      i_awid,
  input  logic [axiw_pkg::USER_W-1:0]    i_awuser,
  output logic                           o_awready,

  // AXI write data
  input  logic                           i_wvalid,
  input  logic [axiw_pkg::DATA_W-1:0]    i_wdata,
  input  logic [axiw_pkg::STRB_W-1:0]    i_wstrb,
  output logic                           o_wready,

  // AXI write response
  output logic                           o_bvalid,
  output logic [axiw_pkg::ID_W-1:0]      o_bid,
  output logic [1:0]                     o_bresp,
  output logic [axiw_pkg::USER_W-1:0]    o_buser,
  input  logic                           i_bready,

  // Register read-back
  input  logic [axiw_pkg::REG_IDX_W-1:0] i_rd_idx,
  output logic [axiw_pkg::DATA_W-1:0]    o_rd_data
);

  axil_wr_if axil_link ();

  axi_axil_reflect_wr u_reflect (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_awvalid(i_awvalid),
    .i_awaddr (i_awaddr),
    .i_awid   (i_awid),
    .i_awuser (i_awuser),
    .o_awready(o_awready),
    .i_wvalid (i_wvalid),
    .i_wdata  (i_wdata),
    .i_wstrb  (i_wstrb),
    .o_wready (o_wready),
    .o_bvalid (o_bvalid),
    .o_bid    (o_bid),
    .o_bresp  (o_bresp),
    .o_buser  (o_buser),
    .i_bready (i_bready),
    .m_axil   (axil_link.mgr)
  );

  axil_reg_bank u_reg_bank (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .s_axil   (axil_link.sub),
    .i_rd_idx (i_rd_idx),
    .o_rd_data(o_rd_data)
  );

endmodule

// File: rtl/axil_reg_bank.sv
`timescale 1ns/1ps

module axil_reg_bank (
  input  logic                           clk,
  input  logic                           i_rst_n,
  axil_wr_if.sub                         s_axil,
  input  logic [axiw_pkg::REG_IDX_W-1:0] i_rd_idx,
  output logic [axiw_pkg::DATA_W-1:0]    o_rd_data
);
  import axiw_pkg::*;

  logic [DATA_W-1:0]    regs [NUM_REGS];
  logic [REG_IDX_W-1:0] wr_idx;
  logic                 in_range;
  logic                 accept;
  logic                 bvalid_q;
  logic [1:0]           bresp_q;

  // Address and data are taken together, one response at a time
  assign accept = s_axil.awvalid && s_axil.wvalid && !bvalid_q;

  assign s_axil.awready = accept;
  assign s_axil.wready  = accept;

  // Halfword registers, byte address bit 0 ignored
  assign wr_idx   = s_axil.awaddr[REG_IDX_W:1];
  assign in_range = (s_axil.awaddr < ADDR_W'(NUM_REGS * 2));

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (accept && in_range) begin
      // Merge only the strobed bytes
      for (int b = 0; b < STRB_W; b++) begin
        if (s_axil.wstrb[b]) begin
          regs[wr_idx][b*8 +: 8] <= s_axil.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      bvalid_q <= 1'b0;
    end else if (accept) begin
      bvalid_q <= 1'b1;
    end else if (s_axil.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      bresp_q <= in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign s_axil.bvalid = bvalid_q;
  assign s_axil.bresp  = bresp_q;

  // Read-back port
  assign o_rd_data = regs[i_rd_idx];

endmodule

// File: rtl/axi_axil_reflect_wr.sv
`timescale 1ns/1ps

module axi_axil_reflect_wr (
  input  logic                        clk,
  input  logic                        i_rst_n,

  // AXI write address
  input  logic                        i_awvalid,
  input  logic [axiw_pkg::ADDR_W-1:0] i_awaddr,
  input  logic [axiw_pkg::ID_W-1:0]   i_awid,
  input  logic [axiw_pkg::USER_W-1:0] i_awuser,
  output logic                        o_awready,

  // AXI write data
  input  logic                        i_wvalid,
  input  logic [axiw_pkg::DATA_W-1:0] i_wdata,
  input  logic [axiw_pkg::STRB_W-1:0] i_wstrb,
  output logic                        o_wready,

  // AXI write response
  output logic                        o_bvalid,
  output logic [axiw_pkg::ID_W-1:0]   o_bid,
  output logic [1:0]                  o_bresp,
  output logic [axiw_pkg::USER_W-1:0] o_buser,
  input  logic                        i_bready,

  axil_wr_if.mgr                      m_axil
);
  import axiw_pkg::*;

  logic aw_full_n;
  logic w_full_n;
  logic id_full_n;
  logic aw_push;
  logic w_push;
  logic b_pop;

  assign aw_push = i_awvalid && o_awready;
  assign w_push  = i_wvalid && o_wready;
  assign b_pop   = o_bvalid && i_bready;

  // Room in the ID FIFO caps the writes in flight
  assign o_awready = aw_full_n && id_full_n;
  assign o_wready  = w_full_n && id_full_n;

  sync_fifo_zl #(
    .DATA_W_P(ADDR_W),
    .DEPTH   (AW_DEPTH)
  ) u_aw_fifo (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_w_inc    (aw_push),
    .i_w_data   (i_awaddr),
    .o_w_full_n (aw_full_n),
    .i_r_inc    (m_axil.awvalid && m_axil.awready),
    .o_r_data   (m_axil.awaddr),
    .o_r_empty_n(m_axil.awvalid)
  );

  sync_fifo_zl #(
    .DATA_W_P(DATA_W + STRB_W),
    .DEPTH   (W_DEPTH)
  ) u_w_fifo (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_w_inc    (w_push),
    .i_w_data   ({i_wstrb, i_wdata}),
    .o_w_full_n (w_full_n),
    .i_r_inc    (m_axil.wvalid && m_axil.wready),
    .o_r_data   ({m_axil.wstrb, m_axil.wdata}),
    .o_r_empty_n(m_axil.wvalid)
  );

  // ID and user wait here until their response is taken
  sync_fifo_zl #(
    .DATA_W_P(ID_W + USER_W),
    .DEPTH   (ID_DEPTH)
  ) u_id_fifo (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_w_inc    (aw_push),
    .i_w_data   ({i_awid, i_awuser}),
    .o_w_full_n (id_full_n),
    .i_r_inc    (b_pop),
    .o_r_data   ({o_bid, o_buser}),
    .o_r_empty_n()
  );

  // B channel passes through
  assign o_bvalid      = m_axil.bvalid;
  assign o_bresp       = m_axil.bresp;
  assign m_axil.bready = i_bready;

endmodule

// File: rtl/sync_fifo_zl.sv
`timescale 1ns/1ps

module sync_fifo_zl #(
  parameter int DATA_W_P = 8,
  parameter int DEPTH    = 1
) (
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_w_inc,
  input  logic [DATA_W_P-1:0] i_w_data,
  output logic                o_w_full_n,
  input  logic                i_r_inc,
  output logic [DATA_W_P-1:0] o_r_data,
  output logic                o_r_empty_n
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_W_P-1:0] mem [DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;
  logic                empty;
  logic                wr_en;
  logic                rd_en;

  assign empty = (count == '0);

  // Write into an empty FIFO goes straight to the output
  assign o_r_empty_n = !empty || i_w_inc;
  assign o_r_data    = empty ? i_w_data : mem[rd_ptr];
  assign o_w_full_n  = (count != CNT_W'(DEPTH));

  // Bypassed word read in the same cycle is never stored
  assign wr_en = i_w_inc && !(empty && i_r_inc);
  assign rd_en = i_r_inc && !empty;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_w_data;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: rtl/axil_wr_if.sv
`timescale 1ns/1ps

interface axil_wr_if;
  import axiw_pkg::*;

  // Write address
  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;

  // Write data
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              wvalid;
  logic              wready;

  // Write response
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;

  modport mgr (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  awready, wready, bresp, bvalid
  );

  modport sub (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output awready, wready, bresp, bvalid
  );

endinterface

// File: rtl/axiw_pkg.sv
package axiw_pkg;

  // Bus widths
  localparam int ADDR_W = 8;
  localparam int DATA_W = 16;
  localparam int STRB_W = DATA_W / 8;
  localparam int ID_W   = 4;
  localparam int USER_W = 1;

  // FIFO depths in the reflect stage
  localparam int AW_DEPTH = 1;
  localparam int W_DEPTH  = 1;

  // Writes allowed in flight before B, also the ID FIFO depth
  localparam int ID_DEPTH = 2;

  // Register bank size
  localparam int NUM_REGS  = 16;
  localparam int REG_IDX_W = 4;

  // B response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
